//--- verilog.f
hw/femtoPkg.sv
hw/instrDecoder.sv
hw/registerFile.sv
hw/serialDivider.sv
hw/intAlu.sv
hw/loadStoreUnit.sv
hw/femtoCore.sv
verification/clockGen.sv
verification/memoryModel.sv
verification/femtoCoreTb.sv

//--- Bender.yml
package:
  name: femto_core

sources:
  - target: rtl
    files:
      - hw/femtoPkg.sv
      - hw/instrDecoder.sv
      - hw/registerFile.sv
      - hw/serialDivider.sv
      - hw/intAlu.sv
      - hw/loadStoreUnit.sv
      - hw/femtoCore.sv
  - target: test
    files:
      - verification/clockGen.sv
      - verification/memoryModel.sv
      - verification/femtoCoreTb.sv

//--- verification/testProgram.hex
// One RV32 word per line, word address 0 upward
// Results go to 0x100 + 4*index, byte lanes to 0x180, marker to 0x1FC
800000B7
00708093
00300113
00208233
10402023
40208233
10402223
0020A233
10402423
0020B233
10402623
0020C233
10402823
0020E233
10402A23
0020F233
10402C23
00209233
10402E23
0020D233
12402023
4020D233
12402223
02208233
12402423
02209233
12402623
0220B233
12402823
0220C233
12402A23
0220E233
12402C23
0200D233
12402E23
0200F233
14402023
000082B7
0FF28293
18501023
18501123
18500223
185002A3
18500323
185003A3
18300303
14602223
18004303
14602423
18201303
14602623
18005303
14602823
00210463
1E002C23
00211463
14202A23
0080046F
1E002C23
14802C23
000064B7
00D48493
1E902E23
0000006F

//--- verification/femtoCoreTb.sv
// Testbench top for the RV32IM core, checks every bus write against the expected table
`timescale 1ns/1ps

module femtoCoreTb import femtoPkg::*; ();

   localparam logic [31:0] OP_A        = 32'h8000_0007;
   localparam logic [31:0] OP_B        = 32'h0000_0003;
   localparam logic [15:0] HALF_PAT    = 16'h80FF;
   localparam logic [31:0] RESULT_BASE = 32'h0000_0100;
   localparam logic [31:0] LANE_ADDR   = 32'h0000_0180; // SB/SH target word
   localparam logic [31:0] POISON_ADDR = 32'h0000_01F8;
   localparam logic [31:0] DONE_ADDR   = 32'h0000_01FC;
   localparam logic [31:0] DONE_VALUE  = 32'h0000_600D;
   localparam logic [31:0] JAL_ADDR    = 32'h0000_00E4; // Linking JAL in the image
   localparam int NUM_WRITES = 30;
   localparam int NUM_INSTR  = 64;
   localparam int TIMEOUT_NS = NUM_INSTR * 45 * 40 * 2;

   logic    clk, reset;
   memReq_t memReq;
   memRsp_t memRsp;

   string       expName [NUM_WRITES];
   logic [31:0] expAddr [NUM_WRITES];
   logic [3:0]  expMask [NUM_WRITES];
   logic [31:0] expData [NUM_WRITES];
   int          expCount   = 0;
   int          wrIdx      = 0;   // Bus writes seen so far
   int          errorCount = 0;
   logic        seenFetch  = 1'b0;
   logic        done       = 1'b0;

   clockGen clockGen_i (.clk(clk), .reset(reset));

   memoryModel memory_i (.clk(clk), .reset(reset), .memReq(memReq), .memRsp(memRsp));

   femtoCore dut_i (.clk(clk), .reset(reset), .memReq(memReq), .memRsp(memRsp));

   function automatic logic [31:0] expandMask(input logic [3:0] mask);
      return {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
   endfunction

   task automatic expectWrite(input string name, input logic [31:0] addr,
                              input logic [3:0] mask, input logic [31:0] data);
      expName[expCount] = name;
      expAddr[expCount] = addr;
      expMask[expCount] = mask;
      expData[expCount] = data;
      expCount++;
   endtask

   task automatic expectResult(input string name, input logic [31:0] data);
      expectWrite(name, RESULT_BASE + 4 * expCount, 4'b1111, data); // Results come first
   endtask

   // Expected table, in program order
   initial begin
      logic signed [63:0] prodS;
      logic        [63:0] prodU;
      logic        [31:0] laneWord;
      prodS = $signed({{32{OP_A[31]}}, OP_A}) * $signed({{32{OP_B[31]}}, OP_B});
      prodU = {32'b0, OP_A} * {32'b0, OP_B};
      laneWord = {HALF_PAT, HALF_PAT};             // Word after both SH
      expectResult("ADD", OP_A + OP_B);
      expectResult("SUB", OP_A - OP_B);
      expectResult("SLT", {31'b0, $signed(OP_A) < $signed(OP_B)});
      expectResult("SLTU", {31'b0, OP_A < OP_B});
      expectResult("XOR", OP_A ^ OP_B);
      expectResult("OR", OP_A | OP_B);
      expectResult("AND", OP_A & OP_B);
      expectResult("SLL", OP_A << OP_B[4:0]);
      expectResult("SRL", OP_A >> OP_B[4:0]);
      expectResult("SRA", $signed(OP_A) >>> OP_B[4:0]);
      expectResult("MUL", prodU[31:0]);
      expectResult("MULH", prodS[63:32]);
      expectResult("MULHU", prodU[63:32]);
      expectResult("DIV", $signed(OP_A) / $signed(OP_B));
      expectResult("REM", $signed(OP_A) % $signed(OP_B));
      expectResult("DIVU by zero", 32'hFFFF_FFFF);  // All ones
      expectResult("REMU by zero", OP_A);           // Dividend back
      expectWrite("SH low", LANE_ADDR, 4'b0011, laneWord);
      expectWrite("SH high", LANE_ADDR + 2, 4'b1100, laneWord);
      for (int b = 0; b < 4; b++) begin
         expectWrite($sformatf("SB lane %0d", b), LANE_ADDR + 4 + b, 4'b0001 << b,
                     {4{HALF_PAT[7:0]}});
      end
      expectWrite("LB", RESULT_BASE + 4 * 17, 4'b1111, {{24{laneWord[31]}}, laneWord[31:24]});
      expectWrite("LBU", RESULT_BASE + 4 * 18, 4'b1111, {24'b0, laneWord[7:0]});
      expectWrite("LH", RESULT_BASE + 4 * 19, 4'b1111, {{16{laneWord[31]}}, laneWord[31:16]});
      expectWrite("LHU", RESULT_BASE + 4 * 20, 4'b1111, {16'b0, laneWord[15:0]});
      expectWrite("BNE fall-through", RESULT_BASE + 4 * 21, 4'b1111, OP_B);
      expectWrite("JAL link", RESULT_BASE + 4 * 22, 4'b1111, JAL_ADDR + 4);
      expectWrite("done marker", DONE_ADDR, 4'b1111, DONE_VALUE);
   end

   always @(posedge clk) begin
      if (reset && memReq.rstrb) seenFetch <= 1'b1;
      if (reset && |memReq.wmask) begin
         wrIdx <= wrIdx + 1;
         if (memReq.addr == DONE_ADDR && memReq.wdata == DONE_VALUE) done <= 1'b1;
      end
   end

   quietUntilFetch: assert property (@(posedge clk) disable iff (!reset)
                                     !seenFetch |-> memReq.wmask == '0)
      else begin
         errorCount++;
         $display("Bus write issued before the first fetch");
      end
   firstFetchAddr: assert property (@(posedge clk) disable iff (!reset)
                                    (memReq.rstrb && !seenFetch) |-> memReq.addr == RESET_ADDR)
      else begin
         errorCount++;
         $display("Error first fetch: expected %h, actual %h", RESET_ADDR,
                  $sampled(memReq.addr));
      end
   noStrobeWhileBusy: assert property (@(posedge clk) disable iff (!reset)
                                       (memRsp.rbusy || memRsp.wbusy) |-> !memReq.rstrb)
      else begin
         errorCount++;
         $display("Read strobe raised while the memory was still busy");
      end
   poisonUntouched: assert property (@(posedge clk) disable iff (!reset)
                                     |memReq.wmask |-> memReq.addr != POISON_ADDR)
      else begin
         errorCount++;
         $display("Skipped store reached the poison address");
      end
   writeCountOk: assert property (@(posedge clk) disable iff (!reset)
                                  |memReq.wmask |-> wrIdx < NUM_WRITES)
      else begin
         errorCount++;
         $display("More bus writes than the program issues");
      end
   writeAddrOk: assert property (@(posedge clk) disable iff (!reset)
                                 (|memReq.wmask && wrIdx < NUM_WRITES)
                                 |-> memReq.addr == expAddr[wrIdx])
      else begin
         errorCount++;
         $display("Error %s address: expected %h, actual %h", expName[$sampled(wrIdx)],
                  expAddr[$sampled(wrIdx)], $sampled(memReq.addr));
      end
   writeMaskOk: assert property (@(posedge clk) disable iff (!reset)
                                 (|memReq.wmask && wrIdx < NUM_WRITES)
                                 |-> memReq.wmask == expMask[wrIdx])
      else begin
         errorCount++;
         $display("Error %s mask: expected %b, actual %b", expName[$sampled(wrIdx)],
                  expMask[$sampled(wrIdx)], $sampled(memReq.wmask));
      end
   // Only the enabled lanes carry meaning
   writeDataOk: assert property (@(posedge clk) disable iff (!reset)
                                 (|memReq.wmask && wrIdx < NUM_WRITES)
                                 |-> (memReq.wdata & expandMask(memReq.wmask)) ==
                                     (expData[wrIdx] & expandMask(memReq.wmask)))
      else begin
         errorCount++;
         $display("Error %s data: expected %h, actual %h", expName[$sampled(wrIdx)],
                  expData[$sampled(wrIdx)], $sampled(memReq.wdata));
      end

   initial begin
      void'($urandom(32'h46d0));
      wait (done);
      repeat (4) @(posedge clk);                    // Let trailing checks settle
      if (wrIdx != NUM_WRITES) begin
         errorCount++;
         $display("Program finished after %0d of %0d bus writes", wrIdx, NUM_WRITES);
      end
      $display("Errors: %0d, bus writes: %0d of %0d", errorCount, wrIdx, NUM_WRITES);
      if (errorCount == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   // Worst case of 45 cycles per instruction, doubled
   initial begin
      #(TIMEOUT_NS);
      $display("Watchdog expired after %0d ns without the done marker", TIMEOUT_NS);
      $display("Errors: %0d, bus writes: %0d of %0d", errorCount, wrIdx, NUM_WRITES);
      $display("Simulation failed");
      $finish;
   end

endmodule

//--- verification/memoryModel.sv
// Word memory for the core bus, loaded from the program image, with random busy stretching
`timescale 1ns/1ps

module memoryModel import femtoPkg::*; (
   input  logic    clk,
   input  logic    reset,
   input  memReq_t memReq,
   output memRsp_t memRsp
);

   localparam int MEM_WORDS = 128;  // Covers 0x000 to 0x1FF

   logic [XLEN-1:0] mem [MEM_WORDS];
   logic [1:0]      readStall, writeStall; // Remaining busy cycles
   logic [6:0]      wordIndex;

   assign wordIndex = memReq.addr[8:2];

   initial begin
      for (int i = 0; i < MEM_WORDS; i++) begin
         mem[i] = 32'hBAD0_0000 | (i << 2); // Fill tagged with the byte address
      end
      $readmemh("verification/testProgram.hex", mem);
      memRsp     = '0;
      readStall  = '0;
      writeStall = '0;
   end

   always @(posedge clk) begin
      int unsigned stall;
      if (!reset) begin
         memRsp.rbusy <= 1'b0;
         memRsp.wbusy <= 1'b0;
         readStall    <= '0;
         writeStall   <= '0;
      end else begin
         if (memReq.rstrb) begin
            stall = $urandom % 4;
            memRsp.rdata <= mem[wordIndex]; // Held until the next strobe
            readStall    <= stall[1:0];
            memRsp.rbusy <= (stall != 0);
         end else if (readStall != 0) begin
            readStall    <= readStall - 1'b1;
            memRsp.rbusy <= (readStall > 1);
         end
         if (|memReq.wmask) begin
            stall = $urandom % 4;
            for (int b = 0; b < 4; b++) begin
               if (memReq.wmask[b]) mem[wordIndex][8*b +: 8] <= memReq.wdata[8*b +: 8];
            end
            writeStall   <= stall[1:0];
            memRsp.wbusy <= (stall != 0);
         end else if (writeStall != 0) begin
            writeStall   <= writeStall - 1'b1;
            memRsp.wbusy <= (writeStall > 1);
         end
      end
   end

endmodule

//--- verification/clockGen.sv
// Clock and reset source for the testbench, 40 ns period and four-cycle reset
`timescale 1ns/1ps

module clockGen (
   output logic clk,
   output logic reset
);

   initial begin
      clk   = 1'b0;
      reset = 1'b0;                 // Active low, held from time zero
      repeat (4) @(posedge clk);
      reset <= 1'b1;
   end

   always #20 clk = ~clk;           // Half of 40 ns

endmodule

//--- hw/femtoCore.sv
// RV32IM multi-cycle core top with the PC, four-state FSM, write-back select and bus drive
`timescale 1ns/1ps

module femtoCore import femtoPkg::*; (
   input  logic    clk,
   input  logic    reset,
   output memReq_t memReq,
   input  memRsp_t memRsp
);

   coreState_t             state;
   logic [ADDR_WIDTH-1:0]  pc;
   logic [XLEN-1:0]        instr;        // Latched instruction word
   decodedInstr_t          dec;

   logic [XLEN-1:0]        rs1, rs2;
   logic [XLEN-1:0]        aluOut, aluPlus;
   logic                   predicate, aluBusy;

   logic [ADDR_WIDTH-1:0]  lsuAddr;
   logic [XLEN-1:0]        lsuWdata, loadData;
   logic [XLEN/8-1:0]      storeMask;

   logic [ADDR_WIDTH-1:0]  pcPlus4, pcPlusImm, pcNext;
   logic [XLEN-1:0]        writeBackData;
   logic                   writeBack, needToWait, memIdle, fetchPhase;

   instrDecoder decoder_i (
      .instr(instr),
      .dec  (dec)
   );

   // Register indices come straight off the fetch data
   registerFile regFile_i (
      .clk        (clk),
      .readEnable (state == WAIT_INSTR && !memRsp.rbusy),
      .rs1Index   (memRsp.rdata[19:15]),
      .rs2Index   (memRsp.rdata[24:20]),
      .writeEnable(writeBack),
      .rdIndex    (dec.rd),
      .writeData  (writeBackData),
      .rs1        (rs1),
      .rs2        (rs2)
   );

   intAlu alu_i (
      .clk      (clk),
      .reset    (reset),
      .start    (state == EXECUTE && (dec.isAluImm || dec.isAluReg)),
      .dec      (dec),
      .rs1      (rs1),
      .rs2      (rs2),
      .aluOut   (aluOut),
      .aluPlus  (aluPlus),
      .predicate(predicate),
      .aluBusy  (aluBusy)
   );

   loadStoreUnit lsu_i (
      .rs1      (rs1),
      .rs2      (rs2),
      .dec      (dec),
      .rdata    (memRsp.rdata),
      .addr     (lsuAddr),
      .wdata    (lsuWdata),
      .storeMask(storeMask),
      .loadData (loadData)
   );

   // PC adders. JAL, AUIPC and branches share one
   assign pcPlus4   = pc + ADDR_WIDTH'(4);
   assign pcPlusImm = pc + (dec.isJal   ? dec.Jimm[ADDR_WIDTH-1:0] :
                            dec.isAuipc ? dec.Uimm[ADDR_WIDTH-1:0] :
                                          dec.Bimm[ADDR_WIDTH-1:0]);
   assign pcNext = dec.isJalr                              ? {aluPlus[ADDR_WIDTH-1:1], 1'b0} :
                   (dec.isJal | (dec.isBranch & predicate)) ? pcPlusImm :
                                                             pcPlus4;

   always_comb begin
      writeBackData =
         (dec.isLui                  ? dec.Uimm                                       : '0) |
         ((dec.isAluImm | dec.isAluReg) ? aluOut                                      : '0) |
         (dec.isAuipc                ? {{(XLEN-ADDR_WIDTH){1'b0}}, pcPlusImm}         : '0) |
         ((dec.isJal | dec.isJalr)   ? {{(XLEN-ADDR_WIDTH){1'b0}}, pcPlus4}           : '0) | // Link
         (dec.isLoad                 ? loadData                                       : '0);
   end

   assign needToWait = dec.isLoad | dec.isStore | dec.isDivide;
   assign memIdle    = !aluBusy && !memRsp.rbusy && !memRsp.wbusy;

   // Single write per instruction at EXECUTE or at the end of the wait
   assign writeBack = ~(dec.isBranch | dec.isStore) &
                      ((state == EXECUTE && !needToWait) ||
                       (state == WAIT_ALU_OR_MEM && memIdle));

   assign fetchPhase   = (state == FETCH_INSTR) || (state == WAIT_INSTR);
   assign memReq.addr  = {{(XLEN-ADDR_WIDTH){1'b0}},
                          fetchPhase ? {pc[ADDR_WIDTH-1:2], 2'b00} : lsuAddr};
   assign memReq.wdata = lsuWdata;
   assign memReq.wmask = {(XLEN/8){state == EXECUTE && dec.isStore}} & storeMask;
   assign memReq.rstrb = (state == FETCH_INSTR) || (state == EXECUTE && dec.isLoad);

   always_ff @(posedge clk) begin
      if (!reset) begin
         state <= WAIT_ALU_OR_MEM; // Let any pending bus activity drain
         pc    <= RESET_ADDR[ADDR_WIDTH-1:0];
         instr <= '0;              // Decodes as a harmless load to x0
      end else begin
         unique case (state)
            FETCH_INSTR: state <= WAIT_INSTR;
            WAIT_INSTR: begin
               if (!memRsp.rbusy) begin
                  instr <= memRsp.rdata;
                  state <= EXECUTE;
               end
            end
            EXECUTE: begin
               pc    <= pcNext;
               state <= needToWait ? WAIT_ALU_OR_MEM : FETCH_INSTR;
            end
            WAIT_ALU_OR_MEM: begin
               if (memIdle) state <= FETCH_INSTR;
            end
         endcase
      end
   end

   noReadWriteOverlap: assert property (@(posedge clk) disable iff (!reset)
                                        !(memReq.rstrb && |memReq.wmask))
      else $error("read strobe and write mask together");

endmodule

//--- hw/loadStoreUnit.sv
// Load/store unit with effective address, store lane steering, write mask and load extension
`timescale 1ns/1ps

module loadStoreUnit import femtoPkg::*; (
   input  logic [XLEN-1:0]       rs1,
   input  logic [XLEN-1:0]       rs2,
   input  decodedInstr_t         dec,
   input  logic [XLEN-1:0]       rdata,
   output logic [ADDR_WIDTH-1:0] addr,
   output logic [XLEN-1:0]       wdata,
   output logic [XLEN/8-1:0]     storeMask,
   output logic [XLEN-1:0]       loadData
);

   logic        byteAccess, halfAccess, loadSign;
   logic [15:0] loadHalf;
   logic [7:0]  loadByte;

   assign addr = rs1[ADDR_WIDTH-1:0] +
                 (dec.isStore ? dec.Simm[ADDR_WIDTH-1:0] : dec.Iimm[ADDR_WIDTH-1:0]);

   // funct3[1:0] is 00 for byte, 01 for half and 10 for word
   assign byteAccess = dec.funct3Is[0] | dec.funct3Is[4];
   assign halfAccess = dec.funct3Is[1] | dec.funct3Is[5];

   // Replicate low bytes so every lane sees the right data
   assign wdata[7:0]   = rs2[7:0];
   assign wdata[15:8]  = addr[0] ? rs2[7:0] : rs2[15:8];
   assign wdata[23:16] = addr[1] ? rs2[7:0] : rs2[23:16];
   assign wdata[31:24] = addr[0] ? rs2[7:0] : addr[1] ? rs2[15:8] : rs2[31:24];

   always_comb begin
      if (byteAccess) begin
         storeMask = 4'b0001 << addr[1:0];
      end else if (halfAccess) begin
         storeMask = addr[1] ? 4'b1100 : 4'b0011;
      end else begin
         storeMask = 4'b1111; // Word
      end
   end

   // Lane select from the aligned word
   assign loadHalf = addr[1] ? rdata[31:16] : rdata[15:0];
   assign loadByte = addr[0] ? loadHalf[15:8] : loadHalf[7:0];
   assign loadSign = ~(dec.funct3Is[4] | dec.funct3Is[5]) & // LBU/LHU zero-extend
                     (byteAccess ? loadByte[7] : loadHalf[15]);

   assign loadData = byteAccess ? {{24{loadSign}}, loadByte} :
                     halfAccess ? {{16{loadSign}}, loadHalf} :
                                  rdata;

endmodule

//--- hw/intAlu.sv
// Integer ALU with shared subtractor, reversible shifter, multiplier and branch predicate
`timescale 1ns/1ps

module intAlu import femtoPkg::*; (
   input  logic            clk,
   input  logic            reset,
   input  logic            start,    // EXECUTE of an ALU instruction
   input  decodedInstr_t   dec,
   input  logic [XLEN-1:0] rs1,
   input  logic [XLEN-1:0] rs2,
   output logic [XLEN-1:0] aluOut,
   output logic [XLEN-1:0] aluPlus,  // Also the JALR target
   output logic            predicate,
   output logic            aluBusy
);

   logic [XLEN-1:0]          aluIn2;
   logic [XLEN:0]            aluMinus;
   logic                     lt, ltu, eq;
   logic [XLEN-1:0]          shifterIn, shifter, leftShift;
   logic [XLEN:0]            shiftWide;
   logic signed [XLEN:0]     mulA, mulB;
   logic [2*XLEN-1:0]        product;
   logic [XLEN-1:0]          divResult, baseOut, mulDivOut;

   assign aluIn2  = (dec.isAluReg | dec.isBranch) ? rs2 : dec.Iimm;
   assign aluPlus = rs1 + aluIn2;

   // One subtraction gives SUB and all three compares
   assign aluMinus = {1'b1, ~aluIn2} + {1'b0, rs1} + (XLEN+1)'(1);
   assign ltu = aluMinus[XLEN];
   assign lt  = (rs1[XLEN-1] ^ aluIn2[XLEN-1]) ? rs1[XLEN-1] : aluMinus[XLEN];
   assign eq  = (aluMinus[XLEN-1:0] == '0);

   // Left shift = reverse, shift right, reverse back
   assign shifterIn = dec.funct3Is[1] ? {<<{rs1}} : rs1;
   assign shiftWide = $signed({dec.subOrArith & dec.funct3Is[5] & rs1[XLEN-1], shifterIn})
                      >>> aluIn2[4:0];
   assign shifter   = shiftWide[XLEN-1:0];
   assign leftShift = {<<{shifter}};

   // MULH signs both operands, MULHSU only rs1
   assign mulA    = {rs1[XLEN-1] & (dec.funct3Is[1] | dec.funct3Is[2]), rs1};
   assign mulB    = {aluIn2[XLEN-1] & dec.funct3Is[1], aluIn2};
   assign product = mulA * mulB;

   always_comb begin
      baseOut =
         (dec.funct3Is[0] ? ((dec.subOrArith & dec.isAluReg) ? aluMinus[XLEN-1:0] : aluPlus)
                          : '0) |
         (dec.funct3Is[1] ? leftShift              : '0) |
         (dec.funct3Is[2] ? {{(XLEN-1){1'b0}}, lt}  : '0) | // SLT
         (dec.funct3Is[3] ? {{(XLEN-1){1'b0}}, ltu} : '0) | // SLTU
         (dec.funct3Is[4] ? rs1 ^ aluIn2            : '0) |
         (dec.funct3Is[5] ? shifter                 : '0) | // SRL/SRA
         (dec.funct3Is[6] ? rs1 | aluIn2            : '0) |
         (dec.funct3Is[7] ? rs1 & aluIn2            : '0);
      mulDivOut =
         (dec.funct3Is[0]    ? product[XLEN-1:0]      : '0) | // MUL
         (|dec.funct3Is[3:1] ? product[2*XLEN-1:XLEN] : '0) | // MULH/MULHSU/MULHU
         (|dec.funct3Is[7:4] ? divResult              : '0);  // DIV/DIVU/REM/REMU
   end

   assign aluOut = dec.isMulDiv ? mulDivOut : baseOut;

   // Branch condition from the shared compare
   assign predicate = (dec.funct3Is[0] &  eq)  |
                      (dec.funct3Is[1] & ~eq)  |
                      (dec.funct3Is[4] &  lt)  |
                      (dec.funct3Is[5] & ~lt)  |
                      (dec.funct3Is[6] &  ltu) |
                      (dec.funct3Is[7] & ~ltu);

   serialDivider divider_i (
      .clk          (clk),
      .reset        (reset),
      .start        (start & dec.isDivide),
      .dividend     (rs1),
      .divisor      (rs2),
      .isSigned     (dec.funct3Is[4] | dec.funct3Is[6]), // DIV, REM
      .wantRemainder(dec.funct3Is[6] | dec.funct3Is[7]), // REM, REMU
      .result       (divResult),
      .busy         (aluBusy)
   );

endmodule

//--- hw/serialDivider.sv
// Bit-serial restoring divider, one quotient bit per cycle for 32 cycles
`timescale 1ns/1ps

module serialDivider import femtoPkg::*; (
   input  logic            clk,
   input  logic            reset,
   input  logic            start,
   input  logic [XLEN-1:0] dividend,
   input  logic [XLEN-1:0] divisor,
   input  logic            isSigned,
   input  logic            wantRemainder,
   output logic [XLEN-1:0] result,
   output logic            busy
);

   logic [XLEN-1:0]   remReg;     // Running remainder magnitude
   logic [2*XLEN-2:0] divisorReg; // Divisor magnitude, shifted right each step
   logic [XLEN-1:0]   quotReg;
   logic [XLEN-1:0]   quotMask;   // Walking one, marks the current quotient bit
   logic              remSel, negResult;
   logic              stepDo;
   logic [XLEN-1:0]   rawResult;

   assign busy   = |quotMask;
   assign stepDo = (divisorReg <= {{(XLEN-1){1'b0}}, remReg});

   always_ff @(posedge clk) begin
      if (!reset) begin
         quotMask <= '0;
      end else if (start) begin
         quotMask <= {1'b1, {(XLEN-1){1'b0}}};
      end else begin
         quotMask <= quotMask >> 1;
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         remReg     <= (isSigned & dividend[XLEN-1]) ? -dividend : dividend;
         divisorReg <= {((isSigned & divisor[XLEN-1]) ? -divisor : divisor),
                        {(XLEN-1){1'b0}}};
         quotReg    <= '0;
         remSel     <= wantRemainder;
         // Remainder follows the dividend sign; quotient sign skipped for x/0
         negResult  <= isSigned & (wantRemainder ? dividend[XLEN-1]
                          : (dividend[XLEN-1] ^ divisor[XLEN-1]) & |divisor);
      end else if (busy) begin
         if (stepDo) begin
            remReg  <= remReg - divisorReg[XLEN-1:0];
            quotReg <= quotReg | quotMask;
         end
         divisorReg <= divisorReg >> 1;
      end
   end

   assign rawResult = remSel ? remReg : quotReg;
   assign result    = negResult ? -rawResult : rawResult;

   // Core must wait for the previous divide before issuing another
   startWhileBusy: assert property (@(posedge clk) disable iff (!reset) start |-> !busy)
      else $error("divider started while busy");

endmodule

//--- hw/registerFile.sv
// Integer register file, 32 words, registered dual read and single write
`timescale 1ns/1ps

module registerFile import femtoPkg::*; (
   input  logic                        clk,
   input  logic                        readEnable,
   input  logic [$clog2(NUM_REGS)-1:0] rs1Index,
   input  logic [$clog2(NUM_REGS)-1:0] rs2Index,
   input  logic                        writeEnable,
   input  logic [$clog2(NUM_REGS)-1:0] rdIndex,
   input  logic [XLEN-1:0]             writeData,
   output logic [XLEN-1:0]             rs1,
   output logic [XLEN-1:0]             rs2
);

   logic [XLEN-1:0] regs [NUM_REGS];

   always_ff @(posedge clk) begin
      if (writeEnable && rdIndex != '0) begin // x0 stays hardwired
         regs[rdIndex] <= writeData;
      end
      if (readEnable) begin
         rs1 <= (rs1Index == '0) ? '0 : regs[rs1Index]; // x0 reads as zero
         rs2 <= (rs2Index == '0) ? '0 : regs[rs2Index];
      end
   end

endmodule

//--- hw/instrDecoder.sv
// Instruction decoder, turns the latched word into class flags, funct3 and immediates
`timescale 1ns/1ps

module instrDecoder import femtoPkg::*; (
   input  logic [XLEN-1:0] instr,
   output decodedInstr_t   dec
);

   logic [4:0] opcode;
   logic       isSystem;

   assign opcode   = instr[6:2]; // Bits 1:0 are always 11 for 32-bit encodings
   assign isSystem = (opcode == OPC_SYSTEM);

   // Instruction classes
   assign dec.isLoad   = (opcode == OPC_LOAD);
   assign dec.isAluImm = (opcode == OPC_ALUIMM);
   assign dec.isAuipc  = (opcode == OPC_AUIPC);
   assign dec.isStore  = (opcode == OPC_STORE);
   assign dec.isAluReg = (opcode == OPC_ALUREG);
   assign dec.isLui    = (opcode == OPC_LUI);
   assign dec.isBranch = (opcode == OPC_BRANCH);
   assign dec.isJalr   = (opcode == OPC_JALR);
   assign dec.isJal    = (opcode == OPC_JAL);

   // M extension sits in ALUREG with funct7 bit 0 set
   assign dec.isMulDiv = dec.isAluReg & instr[25];
   assign dec.isDivide = dec.isMulDiv & instr[14]; // funct3 4..7 are DIV/DIVU/REM/REMU

   // SYSTEM retires without a register write, so its rd is forced to x0
   assign dec.rd = isSystem ? '0 : instr[11:7];

   // funct3Is[n] is set when funct3 == n
   assign dec.funct3Is = 8'b0000_0001 << instr[14:12];

   // SUB and SRA/SRAI flag
   assign dec.subOrArith = instr[30];

   // Sign-extended immediates
   assign dec.Uimm = {instr[31:12], 12'b0};
   assign dec.Iimm = {{21{instr[31]}}, instr[30:20]};
   assign dec.Simm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
   assign dec.Bimm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   assign dec.Jimm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

endmodule

//--- hw/femtoPkg.sv
// Shared constants, FSM states and bus/decode structs for the RV32IM core
package femtoPkg;

   localparam int ADDR_WIDTH = 24;               // PC and effective address width
   localparam logic [31:0] RESET_ADDR = 32'h0000_0000;
   localparam int XLEN     = 32;                 // Data path width
   localparam int NUM_REGS = 32;

   // Major opcodes, taken from instr[6:2]
   localparam logic [4:0] OPC_LOAD   = 5'b00000;
   localparam logic [4:0] OPC_ALUIMM = 5'b00100;
   localparam logic [4:0] OPC_AUIPC  = 5'b00101;
   localparam logic [4:0] OPC_STORE  = 5'b01000;
   localparam logic [4:0] OPC_ALUREG = 5'b01100;
   localparam logic [4:0] OPC_LUI    = 5'b01101;
   localparam logic [4:0] OPC_BRANCH = 5'b11000;
   localparam logic [4:0] OPC_JALR   = 5'b11001;
   localparam logic [4:0] OPC_JAL    = 5'b11011;
   localparam logic [4:0] OPC_SYSTEM = 5'b11100; // Treated as no-op

   typedef enum logic [1:0] {
      FETCH_INSTR,
      WAIT_INSTR,
      EXECUTE,
      WAIT_ALU_OR_MEM
   } coreState_t;

   // Core to memory
   typedef struct packed {
      logic [XLEN-1:0]   addr;
      logic [XLEN-1:0]   wdata;
      logic [XLEN/8-1:0] wmask; // One bit per byte lane
      logic              rstrb; // Read strobe, single cycle
   } memReq_t;

   // Memory to core
   typedef struct packed {
      logic [XLEN-1:0] rdata;
      logic            rbusy;
      logic            wbusy;
   } memRsp_t;

   typedef struct packed {
      logic isLoad, isAluImm, isAluReg, isAuipc, isStore, isLui;
      logic isBranch, isJalr, isJal, isMulDiv, isDivide;
      logic [$clog2(NUM_REGS)-1:0] rd;
      logic [7:0]      funct3Is;   // One-hot funct3
      logic            subOrArith; // instr[30]
      logic [XLEN-1:0] Iimm, Simm, Bimm, Jimm, Uimm;
   } decodedInstr_t;

endpackage
